/* simd_wrap_params_pkg.sv */
/*
  Sizing constants for the SIMD result-return path.
  Lane count, word widths and FIFO depths are all taken from here.
*/
package simd_wrap_params_pkg;

  // ----------------------------------------
  // Lanes and word widths
  // ----------------------------------------

  // Execution lanes in the SIMD array
  localparam int NUM_LANES        = 4;

  // One lane result word
  localparam int LANE_WIDTH       = 32;

  // Start and end of stream markers that travel with each result
  localparam int CNTL_WIDTH       = 2;

  // Operation tag from the controller
  localparam int TAG_WIDTH        = 8;

  // Wide enough to hold a count of 0 to NUM_LANES active lanes
  localparam int LANE_COUNT_WIDTH = 3;

  // ----------------------------------------
  // Queue sizing
  // ----------------------------------------

  // Per-lane result FIFO
  // ready drops with two free slots left
  localparam int RESULT_FIFO_DEPTH     = 8;
  localparam int RESULT_FIFO_THRESHOLD = 6;

  // Tag FIFO
  // Its ready is registered, so the
  // two spare slots absorb the extra lag
  localparam int TAG_FIFO_DEPTH     = 4;
  localparam int TAG_FIFO_THRESHOLD = 2;

endpackage

/* simd_wrap_types_pkg.sv */
/*
  Data types shared by the result FIFOs, the tag queue and the
  upstream sequencer. Widths come from the params package.
*/
package simd_wrap_types_pkg;

  import simd_wrap_params_pkg::*;

  // ----------------------------------------
  // Payload types
  // ----------------------------------------

  // One result word from a lane, 34 bits
  typedef struct packed {
    logic [CNTL_WIDTH-1:0] cntl;
    logic [LANE_WIDTH-1:0] data;
  } lane_result_t;

  // One bit per lane for valids, readies and the lane mask
  typedef logic [NUM_LANES-1:0] lane_vec_t;

  // Tag plus the number of lanes that take part, 11 bits
  typedef struct packed {
    logic [TAG_WIDTH-1:0]        tag;
    logic [LANE_COUNT_WIDTH-1:0] num_lanes;
  } tag_entry_t;

  // Everything handed to the stack upstream interface, 147 bits
  typedef struct packed {
    tag_entry_t                    hdr;
    lane_result_t [NUM_LANES-1:0]  lanes;
  } upstream_t;

  // ----------------------------------------
  // Sequencer FSM
  // ----------------------------------------

  typedef enum logic [2:0] {
    WAIT          = 3'd0,
    SEND          = 3'd1,
    WAIT_COMPLETE = 3'd2,
    WAIT_RELEASE  = 3'd3,
    DONE          = 3'd4
  } seq_state_t;

endpackage

/* sync_fifo.sv */
/*
  Single clock FIFO with a show-ahead read port.
  The head entry is valid whenever not_empty is high and a pop
  retires it at the next edge. almost_full is meant for flow control.
*/
module sync_fifo
  import simd_wrap_params_pkg::*, simd_wrap_types_pkg::*;
#(
  parameter type entry_t   = lane_result_t,
  parameter int  DEPTH     = RESULT_FIFO_DEPTH,
  parameter int  THRESHOLD = RESULT_FIFO_THRESHOLD
)
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  entry_t push_data,
  input  logic   pop,
  output entry_t head,
  output logic   not_empty,
  output logic   almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             do_push;
  logic             do_pop;

  // A push into a full FIFO is dropped, a pop from an empty one ignored
  assign do_push = push && (count != CNT_W'(DEPTH));
  assign do_pop  = pop && (count != '0);

  always_comb
  begin
    count_next = count;
    if (do_push && !do_pop)
      count_next = count + 1'b1;
    else if (do_pop && !do_push)
      count_next = count - 1'b1;
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      // Held high so nothing is accepted until reset is over
      almost_full <= 1'b1;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count       <= count_next;
      almost_full <= (count_next >= CNT_W'(THRESHOLD));
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

endmodule

/* tag_queue.sv */
/*
  Tag path from the controller. The incoming tag is registered,
  then queued. tag_ready is registered too, so the controller sees
  a short path and must respect up to two cycles of lag.
*/
module tag_queue
  import simd_wrap_params_pkg::*, simd_wrap_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tag_valid,
  input  tag_entry_t tag_in,
  input  logic       tag_pop,
  output tag_entry_t tag_head,
  output logic       tag_pending,
  output logic       tag_ready
);

  logic       tag_valid_q;
  tag_entry_t tag_q;
  logic       tag_almost_full;

  // ----------------------------------------
  // Input register stage
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      tag_valid_q <= 1'b0;
    else
      tag_valid_q <= tag_valid;
  end

  always_ff @(posedge clk)
  begin
    tag_q <= tag_in;
  end

  // Every registered tag is written. The threshold leaves room for it
  sync_fifo #(
    .entry_t   (tag_entry_t),
    .DEPTH     (TAG_FIFO_DEPTH),
    .THRESHOLD (TAG_FIFO_THRESHOLD)
  ) u_tag_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (tag_valid_q),
    .push_data   (tag_q),
    .pop         (tag_pop),
    .head        (tag_head),
    .not_empty   (tag_pending),
    .almost_full (tag_almost_full)
  );

  // Flow control back to the controller
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      tag_ready <= 1'b0;
    else
      tag_ready <= ~tag_almost_full;
  end

endmodule

/* upstream_sequencer.sv */
/*
  Dispatch FSM toward the stack upstream interface. Once a tag and a
  result on every enabled lane are queued, and the receiver is ready,
  it pops them and sends one registered pulse. It then waits for the
  receiver's complete to rise and fall before the next transfer.
*/
module upstream_sequencer
  import simd_wrap_params_pkg::*, simd_wrap_types_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  lane_vec_t                    lane_mask,
  input  tag_entry_t                   tag_head,
  input  logic                         tag_pending,
  input  lane_result_t [NUM_LANES-1:0] lane_heads,
  input  lane_vec_t                    lane_pending,
  input  logic                         up_ready,
  input  logic                         up_complete,
  output logic                         tag_pop,
  output lane_vec_t                    lane_pop,
  output lane_vec_t                    up_valid,
  output upstream_t                    up_bundle
);

  lane_vec_t  mask_q;
  logic       ready_q;
  logic       complete_q;
  logic       lanes_ok;
  logic       dispatch;
  seq_state_t state;
  seq_state_t state_next;

  // ----------------------------------------
  // Sampled inputs
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      mask_q     <= '0;
      ready_q    <= 1'b0;
      complete_q <= 1'b0;
    end
    else
    begin
      mask_q     <= lane_mask;
      ready_q    <= up_ready;
      complete_q <= up_complete;
    end
  end

  // Disabled lanes never hold up a dispatch
  assign lanes_ok = &(lane_pending | ~mask_q);
  assign dispatch = tag_pending && lanes_ok && ready_q;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= WAIT;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      WAIT:
        if (dispatch)
          state_next = SEND;
      // Pops happen here and the pulse leaves one cycle later
      SEND:
        state_next = WAIT_COMPLETE;
      WAIT_COMPLETE:
        if (complete_q)
          state_next = WAIT_RELEASE;
      WAIT_RELEASE:
        if (!complete_q)
          state_next = DONE;
      DONE:
        state_next = WAIT;
      default:
        state_next = WAIT;
    endcase
  end

  assign tag_pop  = (state == SEND);
  assign lane_pop = (state == SEND) ? mask_q : '0;

  // ----------------------------------------
  // Output register stage
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      up_valid <= '0;
    else if (state == SEND)
      up_valid <= mask_q;
    else
      up_valid <= '0;
  end

  // Payload is only meaningful while up_valid is high
  always_ff @(posedge clk)
  begin
    if (state == SEND)
    begin
      up_bundle.hdr <= tag_head;
      for (int i = 0; i < NUM_LANES; i++)
      begin
        // Zero the disabled lanes so stale FIFO words stay off the bus
        up_bundle.lanes[i] <= mask_q[i] ? lane_heads[i] : '0;
      end
    end
  end

endmodule

/* simd_result_wrapper.sv */
/*
  Result-return side of the PE SIMD wrapper. Per-lane result FIFOs
  and the tag queue feed the upstream sequencer, which hands one
  tag with its lane results to the stack upstream interface.
*/
module simd_result_wrapper
  import simd_wrap_params_pkg::*, simd_wrap_types_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,

  // Results from the streaming unit
  input  lane_vec_t                    res_valid,
  input  lane_result_t [NUM_LANES-1:0] res_data,
  output lane_vec_t                    res_ready,

  // Operation tags from the controller
  input  logic                         tag_valid,
  input  tag_entry_t                   tag_in,
  output logic                         tag_ready,

  // Lanes taking part in the current operation
  input  lane_vec_t                    lane_mask,

  // Stack upstream interface
  input  logic                         up_ready,
  input  logic                         up_complete,
  output lane_vec_t                    up_valid,
  output upstream_t                    up_bundle
);

  lane_result_t [NUM_LANES-1:0] lane_heads;
  lane_vec_t                    lane_pending;
  lane_vec_t                    lane_pop;
  lane_vec_t                    lane_almost_full;
  tag_entry_t                   tag_head;
  logic                         tag_pending;
  logic                         tag_pop;

  // ----------------------------------------
  // Per-lane result FIFOs
  // ----------------------------------------
  for (genvar gi = 0; gi < NUM_LANES; gi++)
  begin : g_lane_fifo
    logic lane_push;

    assign lane_push     = res_valid[gi] & res_ready[gi];
    assign res_ready[gi] = ~lane_almost_full[gi];

    sync_fifo #(
      .entry_t   (lane_result_t),
      .DEPTH     (RESULT_FIFO_DEPTH),
      .THRESHOLD (RESULT_FIFO_THRESHOLD)
    ) u_result_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .push        (lane_push),
      .push_data   (res_data[gi]),
      .pop         (lane_pop[gi]),
      .head        (lane_heads[gi]),
      .not_empty   (lane_pending[gi]),
      .almost_full (lane_almost_full[gi])
    );
  end

  // Tag queue
  tag_queue u_tag_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_valid   (tag_valid),
    .tag_in      (tag_in),
    .tag_pop     (tag_pop),
    .tag_head    (tag_head),
    .tag_pending (tag_pending),
    .tag_ready   (tag_ready)
  );

  // Dispatch toward the stack upstream interface
  upstream_sequencer u_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_mask    (lane_mask),
    .tag_head     (tag_head),
    .tag_pending  (tag_pending),
    .lane_heads   (lane_heads),
    .lane_pending (lane_pending),
    .up_ready     (up_ready),
    .up_complete  (up_complete),
    .tag_pop      (tag_pop),
    .lane_pop     (lane_pop),
    .up_valid     (up_valid),
    .up_bundle    (up_bundle)
  );

endmodule

/* simd_result_wrapper_assertions.sv */
/*
  Bound checker for the result wrapper. Accepted results and tags are
  mirrored in reference queues, and every upstream pulse is checked
  against them together with the reset, mask and handshake rules.
*/
module simd_result_wrapper_assertions
  import simd_wrap_params_pkg::*, simd_wrap_types_pkg::*;
(
  input logic                         clk,
  input logic                         rst_n,
  input lane_vec_t                    res_valid,
  input lane_result_t [NUM_LANES-1:0] res_data,
  input lane_vec_t                    res_ready,
  input logic                         tag_valid,
  input tag_entry_t                   tag_in,
  input logic                         tag_ready,
  input lane_vec_t                    lane_mask,
  input logic                         up_ready,
  input logic                         up_complete,
  input lane_vec_t                    up_valid,
  input upstream_t                    up_bundle
);

  int                           error_count = 0;
  tag_entry_t                   tag_ref [$];
  lane_result_t                 lane_ref [NUM_LANES][$];
  tag_entry_t                   exp_tag;
  lane_result_t [NUM_LANES-1:0] exp_lane;
  logic                         tag_avail;
  lane_vec_t                    lane_avail;
  logic                         reset_q = 1'b0;
  logic                         awaiting;
  logic                         complete_seen;
  logic                         pulse;

  assign pulse = (up_valid != '0);

  // ----------------------------------------
  // Reference queues
  // ----------------------------------------
  always @(posedge clk)
  begin
    reset_q <= !rst_n;
    if (!rst_n)
    begin
      tag_ref.delete();
      for (int i = 0; i < NUM_LANES; i++)
        lane_ref[i].delete();
    end
    else
    begin
      // The pulse sampled at this edge retires the oldest entries
      if (pulse && tag_ref.size() > 0)
        void'(tag_ref.pop_front());
      for (int i = 0; i < NUM_LANES; i++)
      begin
        if (pulse && lane_mask[i] && lane_ref[i].size() > 0)
          void'(lane_ref[i].pop_front());
        if (res_valid[i] && res_ready[i])
          lane_ref[i].push_back(res_data[i]);
      end
      if (tag_valid)
        tag_ref.push_back(tag_in);
    end
    tag_avail <= (tag_ref.size() > 0);
    exp_tag   <= (tag_ref.size() > 0) ? tag_ref[0] : '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      lane_avail[i] <= (lane_ref[i].size() > 0);
      exp_lane[i]   <= (lane_ref[i].size() > 0) ? lane_ref[i][0] : '0;
    end
  end

  // Complete has to rise and fall after each pulse
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      awaiting      <= 1'b0;
      complete_seen <= 1'b0;
    end
    else if (pulse)
    begin
      awaiting      <= 1'b1;
      complete_seen <= 1'b0;
    end
    else if (awaiting && up_complete)
      complete_seen <= 1'b1;
    else if (awaiting && complete_seen)
      awaiting <= 1'b0;
  end

  // ----------------------------------------
  // Properties
  // ----------------------------------------
  a_reset_outputs: assert property (@(posedge clk)
    reset_q |-> (up_valid == '0 && !tag_ready && res_ready == '0))
    else begin error_count++; $error("Outputs were not held low around reset"); end

  a_pulse_has_entries: assert property (@(posedge clk) disable iff (!rst_n)
    pulse |-> (tag_avail && ((lane_avail | ~lane_mask) == '1)))
    else begin error_count++; $error("Upstream pulse sent without accepted entries"); end

  a_tag_order: assert property (@(posedge clk) disable iff (!rst_n)
    pulse |-> (up_bundle.hdr == exp_tag))
    else begin
      error_count++;
      $error("** Error at %0t: up_bundle.hdr = %h, expected %h",
             $time, $sampled(up_bundle.hdr), $sampled(exp_tag));
    end

  for (genvar gi = 0; gi < NUM_LANES; gi++)
  begin : g_lane_check
    lane_result_t lane_exp;

    // Disabled lanes are expected to carry zero
    assign lane_exp = lane_mask[gi] ? exp_lane[gi] : lane_result_t'('0);

    a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
      pulse |-> (up_bundle.lanes[gi] == lane_exp))
      else begin
        error_count++;
        $error("** Error at %0t: up_bundle.lanes[%0d] = %h, expected %h", $time, gi,
               $sampled(up_bundle.lanes[gi]), $sampled(lane_exp));
      end
  end

  a_valid_mask: assert property (@(posedge clk) disable iff (!rst_n)
    pulse |-> (up_valid == lane_mask))
    else begin
      error_count++;
      $error("** Error at %0t: up_valid = %b, expected %b",
             $time, $sampled(up_valid), $sampled(lane_mask));
    end

  a_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    pulse |=> (up_valid == '0))
    else begin error_count++; $error("up_valid stayed high for more than one cycle"); end

  a_wait_complete: assert property (@(posedge clk) disable iff (!rst_n)
    pulse |-> !awaiting)
    else begin error_count++; $error("New pulse before complete rose and fell"); end

  // Three register stages separate up_ready from up_valid
  a_ready_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (!up_ready && !$past(up_ready) && !$past(up_ready, 2) && !$past(up_ready, 3))
      |-> (up_valid == '0))
    else begin error_count++; $error("Pulse sent while up_ready was held low"); end

endmodule

/* tb_simd_result_wrapper.sv */
/*
  Testbench for the SIMD result wrapper. Random results and tags are
  fed in three phases while a receiver model answers upstream. The
  bound checker does the checking.
*/
module tb_simd_result_wrapper
  import simd_wrap_params_pkg::*, simd_wrap_types_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int SEED            = 19552;
  localparam int FULL_OPS        = 10;
  localparam int PARTIAL_OPS     = 10;
  localparam int STALL_OPS       = 8;
  localparam int TOTAL_OPS       = FULL_OPS + PARTIAL_OPS + STALL_OPS;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 200 + 500;

  logic                         clk = 1'b0;
  logic                         rst_n;
  lane_vec_t                    res_valid;
  lane_result_t [NUM_LANES-1:0] res_data;
  lane_vec_t                    res_ready;
  logic                         tag_valid;
  tag_entry_t                   tag_in;
  logic                         tag_ready;
  lane_vec_t                    lane_mask;
  logic                         up_ready;
  logic                         up_complete;
  lane_vec_t                    up_valid;
  upstream_t                    up_bundle;
  logic                         hold_ready_low = 1'b0;
  int                           pulses;

  simd_result_wrapper uut (
    .clk(clk), .rst_n(rst_n),
    .res_valid(res_valid), .res_data(res_data), .res_ready(res_ready),
    .tag_valid(tag_valid), .tag_in(tag_in), .tag_ready(tag_ready),
    .lane_mask(lane_mask),
    .up_ready(up_ready), .up_complete(up_complete),
    .up_valid(up_valid), .up_bundle(up_bundle)
  );

  bind simd_result_wrapper simd_result_wrapper_assertions u_checker (
    .clk(clk), .rst_n(rst_n),
    .res_valid(res_valid), .res_data(res_data), .res_ready(res_ready),
    .tag_valid(tag_valid), .tag_in(tag_in), .tag_ready(tag_ready),
    .lane_mask(lane_mask),
    .up_ready(up_ready), .up_complete(up_complete),
    .up_valid(up_valid), .up_bundle(up_bundle)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_failure(input string why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  // Feeds n_ops tags plus one result per enabled lane, with random gaps
  task automatic drive_ops(input lane_vec_t mask, input int n_ops);
    int   sent_res [NUM_LANES];
    int   sent_tags;
    logic busy;
    sent_tags = 0;
    for (int i = 0; i < NUM_LANES; i++)
      sent_res[i] = 0;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      res_valid = '0;
      tag_valid = 1'b0;
      busy      = (sent_tags < n_ops);
      if (sent_tags < n_ops && tag_ready && $urandom_range(3) != 0)
      begin
        tag_valid        = 1'b1;
        tag_in.tag       = TAG_WIDTH'($urandom);
        tag_in.num_lanes = LANE_COUNT_WIDTH'($countones(mask));
        sent_tags++;
      end
      for (int i = 0; i < NUM_LANES; i++)
      begin
        if (mask[i] && sent_res[i] < n_ops)
        begin
          busy = 1'b1;
          if (res_ready[i] && $urandom_range(3) != 0)
          begin
            res_valid[i]     = 1'b1;
            res_data[i].cntl = CNTL_WIDTH'($urandom);
            res_data[i].data = $urandom;
            sent_res[i]++;
          end
        end
      end
    end
  endtask

  task automatic wait_for_pulses(input int n);
    while (pulses < n)
      @(negedge clk);
    repeat (12) @(negedge clk);
  endtask

  task automatic apply_mask(input lane_vec_t mask);
    lane_mask = mask;
    repeat (2) @(negedge clk);
  endtask

  // ----------------------------------------
  // Upstream receiver model
  // ----------------------------------------
  initial
  begin
    up_ready    = 1'b0;
    up_complete = 1'b0;
    pulses      = 0;
    forever
    begin
      @(negedge clk);
      up_ready = !hold_ready_low && ($urandom_range(1) == 1);
      if (up_valid != '0)
      begin
        pulses++;
        @(negedge clk);
        up_complete = 1'b1;
        repeat ($urandom_range(4, 1)) @(negedge clk);
        up_complete = 1'b0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (uut.u_checker.error_count != 0)
      report_failure("The checker reported an assertion failure");
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("Timeout while waiting for upstream pulses");
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    res_valid  = '0;
    res_data   = '0;
    tag_valid  = 1'b0;
    tag_in     = '0;
    lane_mask  = 4'b1111;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // All lanes enabled
    apply_mask(4'b1111);
    drive_ops(4'b1111, FULL_OPS);
    wait_for_pulses(FULL_OPS);

    // Lanes 0 and 2 only
    apply_mask(4'b0101);
    drive_ops(4'b0101, PARTIAL_OPS);
    wait_for_pulses(FULL_OPS + PARTIAL_OPS);

    // Receiver stalls until every queue has pushed back
    hold_ready_low = 1'b1;
    apply_mask(4'b1111);
    fork
      drive_ops(4'b1111, STALL_OPS);
      begin
        while (tag_ready || res_ready != '0)
          @(negedge clk);
        repeat (20) @(negedge clk);
        hold_ready_low = 1'b0;
      end
    join
    wait_for_pulses(TOTAL_OPS);

    if (uut.u_checker.error_count == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      report_failure("The checker reported assertion failures");
  end

endmodule

/* simd_result_wrapper.f */
simd_wrap_params_pkg.sv
simd_wrap_types_pkg.sv
sync_fifo.sv
tag_queue.sv
upstream_sequencer.sv
simd_result_wrapper.sv
simd_result_wrapper_assertions.sv
tb_simd_result_wrapper.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_simd_result_wrapper
FILELIST  = simd_result_wrapper.f
RUN_ARGS  = +verilator+error+limit+100
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
